//--- Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - include

sources:
  - rtl/iw_pkg.sv
  - rtl/reg_manager.sv
  - rtl/inst_window.sv
  - rtl/exec_unit.sv
  - rtl/ooo_core.sv
  - target: test
    files:
      - tests/tb_ooo_core.sv

//--- include/iw_defs.svh
`ifndef IW_DEFS_SVH
`define IW_DEFS_SVH

// data path width
`define LEN_WORD 32

// architectural register file
`define NUM_AREG 8
`define LEN_AREG 3

// instruction window
`define SIZE_INST_W   4
`define LEN_INST_W_ID 2

// multiplier latency in cycles, counted from acceptance
`define MUL_CYCLES 3

`endif

//--- list.f
+incdir+include
rtl/iw_pkg.sv
rtl/reg_manager.sv
rtl/inst_window.sv
rtl/exec_unit.sv
rtl/ooo_core.sv
tests/tb_ooo_core.sv

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "iw_defs.svh"

module exec_unit (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   order,
    input  wire iw_pkg::issue_t   iss,
    output logic                  accepted,
    output iw_pkg::wb_t           wb
);

    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    typedef enum logic {
        ST_IDLE,
        ST_MUL
    } state_e;

    state_e               state;
    logic [CNT_W-1:0]     mul_cnt;
    logic [`LEN_AREG-1:0] mul_rd;
    logic [`LEN_WORD-1:0] mul_res;
    logic [`LEN_WORD-1:0] alu_res;
    logic                 is_mul;

    assign accepted = order && (state == ST_IDLE);
    assign is_mul   = (iss.exec_type == iw_pkg::EX_MUL);

    always_comb begin
        case (iss.exec_type)
            iw_pkg::EX_ADD,
            iw_pkg::EX_ADDI: alu_res = iss.a + iss.b;
            iw_pkg::EX_SUB:  alu_res = iss.a - iss.b;
            iw_pkg::EX_AND:  alu_res = iss.a & iss.b;
            iw_pkg::EX_XOR:  alu_res = iss.a ^ iss.b;
            default:         alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            mul_cnt  <= '0;
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accepted && is_mul) begin
                        state   <= ST_MUL;
                        mul_cnt <= CNT_W'(`MUL_CYCLES - 1);
                        mul_rd  <= iss.rd;
                        // low 32 bits only
                        mul_res <= iss.a * iss.b;
                    end else if (accepted) begin
                        wb.valid <= 1'b1;
                        wb.rd    <= iss.rd;
                        wb.data  <= alu_res;
                    end
                end
                ST_MUL: begin
                    mul_cnt <= mul_cnt - 1'b1;
                    if (mul_cnt == 1) begin
                        state    <= ST_IDLE;
                        wb.valid <= 1'b1;
                        wb.rd    <= mul_rd;
                        wb.data  <= mul_res;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // one result per multiply, exactly MUL_CYCLES after acceptance
    a_mul_single_wb: assert property (@(posedge clk) disable iff (reset)
        (accepted && is_mul) |-> ##1 (!wb.valid [*(`MUL_CYCLES - 1)]) ##1 wb.valid);

endmodule

`default_nettype wire

//--- rtl/inst_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "iw_defs.svh"

module inst_window (
    input  wire                       clk,
    input  wire                       reset,

    // from decode
    input  wire                       d_done,
    input  wire iw_pkg::dec_info_t    d_info,
    output logic                      accept_able,

    // register manager
    output logic [`LEN_AREG-1:0]      lk_rd,
    output logic [`LEN_AREG-1:0]      lk_rs1,
    output logic [`LEN_AREG-1:0]      lk_rs2,
    output logic                      dispatch,
    input  wire iw_pkg::src_t         src1,
    input  wire iw_pkg::src_t         src2,
    input  wire                       rd_pending,

    // exec
    output logic                      order,
    output iw_pkg::issue_t            iss,
    input  wire                       accepted,
    input  wire iw_pkg::wb_t          wb
);

    iw_pkg::iw_entry_t entry  [`SIZE_INST_W];
    iw_pkg::iw_entry_t woke   [`SIZE_INST_W];
    iw_pkg::iw_entry_t next_e [`SIZE_INST_W];
    iw_pkg::iw_entry_t new_e;

    logic [`SIZE_INST_W-1:0]   ready_vec;
    logic [`LEN_INST_W_ID-1:0] sel_id;
    logic                      take;
    // survivors after issue, also the first free slot
    logic [`LEN_INST_W_ID:0]   n_keep;

    // capture a broadcast result on a matching tag
    function automatic iw_pkg::src_t wake(
        input iw_pkg::src_t s,
        input iw_pkg::wb_t  w
    );
        iw_pkg::src_t r;
        r = s;
        if (!s.ready && w.valid && (w.rd == s.tag)) begin
            r.ready = 1'b1;
            r.value = w.data;
        end
        return r;
    endfunction

    // wakeup, readiness itself is taken from the stored flags
    always_comb begin
        woke = entry;
        for (int i = 0; i < `SIZE_INST_W; i++) begin
            woke[i].src1 = wake(entry[i].src1, wb);
            woke[i].src2 = wake(entry[i].src2, wb);
            ready_vec[i] = entry[i].valid & entry[i].src1.ready & entry[i].src2.ready;
        end
    end

    // oldest ready entry wins
    always_comb begin
        order  = 1'b0;
        sel_id = '0;
        for (int i = 0; i < `SIZE_INST_W; i++) begin
            if (ready_vec[i] && !order) begin
                order  = 1'b1;
                sel_id = `LEN_INST_W_ID'(i);
            end
        end
    end

    always_comb begin
        iss.exec_type = entry[sel_id].exec_type;
        iss.rd        = entry[sel_id].rd;
        iss.a         = entry[sel_id].src1.value;
        iss.b         = (entry[sel_id].exec_type == iw_pkg::EX_ADDI) ?
                        entry[sel_id].imm : entry[sel_id].src2.value;
    end

    assign take = order & accepted;

    // compaction toward slot 0
    always_comb begin
        next_e = woke;
        for (int i = 0; i < `SIZE_INST_W; i++) begin
            next_e[i].valid = 1'b0;
        end
        n_keep = '0;
        for (int j = 0; j < `SIZE_INST_W; j++) begin
            if (woke[j].valid && !(take && (sel_id == j))) begin
                next_e[n_keep[`LEN_INST_W_ID-1:0]] = woke[j];
                n_keep = n_keep + 1'b1;
            end
        end
    end

    assign lk_rd  = d_info.rd;
    assign lk_rs1 = d_info.rs1;
    assign lk_rs2 = d_info.rs2;

    // full window or a second writer to rd stops decode
    assign accept_able = (n_keep < `SIZE_INST_W) && !rd_pending;
    assign dispatch    = d_done & accept_able;

    always_comb begin
        new_e.valid     = 1'b1;
        new_e.exec_type = d_info.exec_type;
        new_e.rd        = d_info.rd;
        new_e.src1      = src1;
        new_e.src2      = src2;
        new_e.imm       = d_info.imm;
        // addi has no second register operand
        if (d_info.exec_type == iw_pkg::EX_ADDI) begin
            new_e.src2.ready = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SIZE_INST_W; i++) begin
                entry[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `SIZE_INST_W; i++) begin
                entry[i] <= next_e[i];
            end
            if (dispatch) begin
                entry[n_keep[`LEN_INST_W_ID-1:0]] <= new_e;
            end
        end
    end

    // compaction keeps slot 0 filled whenever anything is left to issue
    a_order_valid: assert property (@(posedge clk) disable iff (reset)
        order |-> entry[0].valid);

    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        d_done |-> accept_able);

endmodule

`default_nettype wire

//--- rtl/iw_pkg.sv
`default_nettype none

`include "iw_defs.svh"

package iw_pkg;

    // operations understood by the execution unit
    typedef enum logic [2:0] {
        EX_ADD,
        EX_SUB,
        EX_AND,
        EX_XOR,
        EX_ADDI,
        EX_MUL
    } exec_type_e;

    // decoder output
    typedef struct packed {
        exec_type_e           exec_type;
        logic [`LEN_AREG-1:0] rd;
        logic [`LEN_AREG-1:0] rs1;
        logic [`LEN_AREG-1:0] rs2;
        logic [`LEN_WORD-1:0] imm;
    } dec_info_t;

    // source operand, the tag is the register that will produce it
    typedef struct packed {
        logic                 ready;
        logic [`LEN_AREG-1:0] tag;
        logic [`LEN_WORD-1:0] value;
    } src_t;

    typedef struct packed {
        logic                 valid;
        exec_type_e           exec_type;
        logic [`LEN_AREG-1:0] rd;
        src_t                 src1;
        src_t                 src2;
        logic [`LEN_WORD-1:0] imm;
    } iw_entry_t;

    // operands already resolved, b holds imm for addi
    typedef struct packed {
        exec_type_e           exec_type;
        logic [`LEN_AREG-1:0] rd;
        logic [`LEN_WORD-1:0] a;
        logic [`LEN_WORD-1:0] b;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        logic [`LEN_AREG-1:0] rd;
        logic [`LEN_WORD-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

//--- rtl/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "iw_defs.svh"

module ooo_core (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     d_done,
    input  wire iw_pkg::dec_info_t  d_info,
    output logic                    accept_able,
    output iw_pkg::wb_t             wb
);

    logic [`LEN_AREG-1:0] lk_rd;
    logic [`LEN_AREG-1:0] lk_rs1;
    logic [`LEN_AREG-1:0] lk_rs2;
    logic                 dispatch;
    iw_pkg::src_t         src1;
    iw_pkg::src_t         src2;
    logic                 rd_pending;
    logic                 order;
    logic                 accepted;
    iw_pkg::issue_t       iss;

    reg_manager m_reg_manager (
        .clk        (clk),
        .reset      (reset),
        .dispatch   (dispatch),
        .lk_rd      (lk_rd),
        .lk_rs1     (lk_rs1),
        .lk_rs2     (lk_rs2),
        .wb         (wb),
        .src1       (src1),
        .src2       (src2),
        .rd_pending (rd_pending)
    );

    inst_window m_inst_window (
        .clk         (clk),
        .reset       (reset),
        .d_done      (d_done),
        .d_info      (d_info),
        .accept_able (accept_able),
        .lk_rd       (lk_rd),
        .lk_rs1      (lk_rs1),
        .lk_rs2      (lk_rs2),
        .dispatch    (dispatch),
        .src1        (src1),
        .src2        (src2),
        .rd_pending  (rd_pending),
        .order       (order),
        .iss         (iss),
        .accepted    (accepted),
        .wb          (wb)
    );

    // wb also feeds back into the window and register manager
    exec_unit m_exec_unit (
        .clk      (clk),
        .reset    (reset),
        .order    (order),
        .iss      (iss),
        .accepted (accepted),
        .wb       (wb)
    );

endmodule

`default_nettype wire

//--- rtl/reg_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "iw_defs.svh"

module reg_manager (
    input  wire                       clk,
    input  wire                       reset,

    // lookup from the window
    input  wire                       dispatch,
    input  wire [`LEN_AREG-1:0]       lk_rd,
    input  wire [`LEN_AREG-1:0]       lk_rs1,
    input  wire [`LEN_AREG-1:0]       lk_rs2,

    // result broadcast
    input  wire iw_pkg::wb_t          wb,

    output iw_pkg::src_t              src1,
    output iw_pkg::src_t              src2,
    output logic                      rd_pending
);

    logic [`LEN_WORD-1:0] regs [`NUM_AREG];
    logic [`NUM_AREG-1:0] pending;

    // operand read, a writeback in this cycle bypasses the file
    function automatic iw_pkg::src_t lookup(
        input logic [`LEN_AREG-1:0] addr,
        input iw_pkg::wb_t          w
    );
        iw_pkg::src_t s;
        s.tag = addr;
        if (w.valid && (w.rd == addr)) begin
            s.ready = 1'b1;
            s.value = w.data;
        end else begin
            s.ready = ~pending[addr];
            s.value = regs[addr];
        end
        return s;
    endfunction

    always_comb begin
        src1 = lookup(lk_rs1, wb);
        src2 = lookup(lk_rs2, wb);
    end

    // no bypass here, a new writer waits a full cycle after the old one retires
    assign rd_pending = pending[lk_rd];

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < `NUM_AREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.valid) begin
                regs[wb.rd]    <= wb.data;
                pending[wb.rd] <= 1'b0;
            end
            // set wins over clear
            if (dispatch) begin
                pending[lk_rd] <= 1'b1;
            end
        end
    end

    // every result must belong to a writer that went through dispatch
    a_wb_pending: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> pending[wb.rd]);

endmodule

`default_nettype wire

//--- tests/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "iw_defs.svh"

module tb_ooo_core;

    localparam int N_RANDOM   = 400;
    localparam int N_DIRECTED = 18;
    localparam int MAX_CYCLES = 20 * (N_RANDOM + N_DIRECTED) + 200;

    logic              clk;
    logic              reset;
    logic              d_done;
    iw_pkg::dec_info_t d_info;
    logic              accept_able;
    iw_pkg::wb_t       wb;

    // in-order model state
    logic [`LEN_WORD-1:0] model_regs [`NUM_AREG];
    logic [`LEN_WORD-1:0] exp_val    [`NUM_AREG];
    int                   exp_cnt    [`NUM_AREG];
    int                   outstanding;
    int                   cycles;
    bit                   full_seen;

    ooo_core dut0 (
        .clk         (clk),
        .reset       (reset),
        .d_done      (d_done),
        .d_info      (d_info),
        .accept_able (accept_able),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] compute(input iw_pkg::exec_type_e op,
                                            input logic [31:0] a, input logic [31:0] b,
                                            input logic [31:0] imm);
        case (op)
            iw_pkg::EX_ADD:  return a + b;
            iw_pkg::EX_SUB:  return a - b;
            iw_pkg::EX_AND:  return a & b;
            iw_pkg::EX_XOR:  return a ^ b;
            iw_pkg::EX_ADDI: return a + imm;
            default:         return a * b;
        endcase
    endfunction

    // program order execution at the moment of acceptance
    task automatic take_inst(input iw_pkg::dec_info_t info);
        logic [31:0] res;
        check($sformatf("pending_rd_stall_r%0d", info.rd), 0, exp_cnt[info.rd]);
        res = compute(info.exec_type, model_regs[info.rs1], model_regs[info.rs2], info.imm);
        model_regs[info.rd] = res;
        exp_val[info.rd]    = res;
        exp_cnt[info.rd]++;
        outstanding++;
    endtask

    // one cycle of decode, d_done only when the window can take it
    task automatic drive_cycle(input bit want, input iw_pkg::dec_info_t info, output bit sent);
        sent = 1'b0;
        @(posedge clk);
        #2;
        d_done = 1'b0;
        d_info = info;
        #1;
        if (want && accept_able) begin
            take_inst(info);
            d_done = 1'b1;
            sent   = 1'b1;
        end else if (!accept_able && exp_cnt[info.rd] == 0) begin
            full_seen = 1'b1;
        end
    endtask

    task automatic send(input iw_pkg::exec_type_e op, input logic [2:0] rd,
                        input logic [2:0] rs1, input logic [2:0] rs2, input logic [31:0] imm);
        bit sent;
        sent = 1'b0;
        while (!sent) begin
            drive_cycle(1'b1, '{op, rd, rs1, rs2, imm}, sent);
        end
    endtask

    task automatic drain();
        bit sent;
        while (outstanding != 0) begin
            drive_cycle(1'b0, d_info, sent);
        end
        repeat (4) drive_cycle(1'b0, d_info, sent);
    endtask

    // writebacks are stable around the falling edge
    always @(negedge clk) begin
        if (!reset && wb.valid) begin
            check($sformatf("wb_expected_r%0d", wb.rd), 1, exp_cnt[wb.rd] != 0);
            check($sformatf("wb_data_r%0d", wb.rd), exp_val[wb.rd], wb.data);
            exp_cnt[wb.rd]--;
            outstanding--;
        end
        check("occupancy_limit", 1, outstanding <= `SIZE_INST_W + 1);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int unsigned seed_val;
        iw_pkg::dec_info_t info;
        bit sent;
        int n_sent;
        seed_val = $urandom(16555);
        cycles = 0;
        outstanding = 0;
        full_seen = 1'b0;
        d_done = 1'b0;
        d_info = '0;
        for (int i = 0; i < `NUM_AREG; i++) begin
            model_regs[i] = '0;
            exp_cnt[i] = 0;
        end
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        #1;
        check("reset_accept_able", 1, accept_able);
        check("reset_wb_valid", 0, wb.valid);

        // dependent chain through wakeup and bypass
        send(iw_pkg::EX_ADDI, 3'd1, 3'd0, 3'd0, 32'd5);
        send(iw_pkg::EX_ADD,  3'd2, 3'd1, 3'd1, 32'd0);
        send(iw_pkg::EX_MUL,  3'd3, 3'd2, 3'd1, 32'd0);
        send(iw_pkg::EX_SUB,  3'd4, 3'd3, 3'd2, 32'd0);
        // independent ALU ops finish ahead of the multiply
        send(iw_pkg::EX_MUL,  3'd5, 3'd3, 3'd4, 32'd0);
        send(iw_pkg::EX_ADD,  3'd6, 3'd1, 3'd2, 32'd0);
        send(iw_pkg::EX_XOR,  3'd7, 3'd2, 3'd4, 32'd0);
        send(iw_pkg::EX_AND,  3'd0, 3'd3, 3'd1, 32'd0);
        // second writer to r5 while the multiply is in flight
        send(iw_pkg::EX_ADDI, 3'd5, 3'd6, 3'd0, 32'h1234);
        send(iw_pkg::EX_ADD,  3'd1, 3'd5, 3'd7, 32'd0);
        drain();

        // long run of multiplies fills the window
        full_seen = 1'b0;
        for (int i = 0; i < `NUM_AREG; i++) begin
            send(iw_pkg::EX_MUL, 3'(i), 3'(i + 1), 3'd7, 32'd0);
        end
        drain();
        check("accept_able_low_when_full", 1, full_seen);

        n_sent = 0;
        while (n_sent < N_RANDOM) begin
            info.exec_type = iw_pkg::exec_type_e'($urandom % 6);
            info.rd  = 3'($urandom);
            info.rs1 = 3'($urandom);
            info.rs2 = 3'($urandom);
            info.imm = $urandom;
            drive_cycle(($urandom % 4) != 0, info, sent);
            if (sent) n_sent++;
        end
        drain();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
